// File: lrq_vectors.txt
# v0 addr0 v1 addr1 mem_en check | full0 conflict0 index_oh0 | full1 conflict1 index_oh1
# All values hex, check=0 leaves the response to the reference model
1 00001000 1 00002000 0 1 0 0 0001 0 0 0002
1 00001004 1 00003000 0 1 0 1 0001 0 0 0004
1 00004000 1 00004006 0 1 0 0 0008 0 1 0008
1 00005000 1 00002003 0 1 1 0 0000 0 1 0002
0 00000000 1 00006000 0 1 0 0 0000 1 0 0000
1 00005000 1 00005000 0 1 1 0 0000 1 0 0000
0 00000000 0 00000000 0 1 0 0 0000 0 0 0000
0 00000000 0 00000000 1 0 0 0 0000 0 0 0000
0 00000000 0 00000000 1 0 0 0 0000 0 0 0000
1 00001000 1 00007000 1 0 0 0 0000 0 0 0000
1 00008008 1 00009000 1 0 0 0 0000 0 0 0000
0 00000000 1 0000a000 1 0 0 0 0000 0 0 0000
1 00001000 1 00001000 1 0 0 0 0000 0 0 0000
1 0000b000 0 00000000 1 0 0 0 0000 0 0 0000
0 00000000 0 00000000 1 0 0 0 0000 0 0 0000
1 00007000 1 0000c000 1 0 0 0 0000 0 0 0000
1 0000d000 1 0000d004 1 0 0 0 0000 0 0 0000
0 00000000 0 00000000 1 0 0 0 0000 0 0 0000
1 0000e000 1 00001000 1 0 0 0 0000 0 0 0000
0 00000000 1 0000f000 1 0 0 0 0000 0 0 0000
1 00002000 1 00003008 1 0 0 0 0000 0 0 0000
0 00000000 0 00000000 1 0 0 0 0000 0 0 0000

// File: lrq.f
lrq_mem_pkg.sv
lrq_lsu_pkg.sv
lrq_req_decode.sv
lrq_entry_array.sv
lrq_refill_result.sv
lrq_top.sv
lrq_tb.sv

// File: Bender.yml
package:
  name: lrq

sources:
  - lrq_mem_pkg.sv
  - lrq_lsu_pkg.sv
  - lrq_req_decode.sv
  - lrq_entry_array.sv
  - lrq_refill_result.sv
  - lrq_top.sv
  - target: simulation
    files:
      - lrq_tb.sv

// File: lrq_tb.sv
`timescale 1ns/100ps

module lrq_tb
  import lrq_mem_pkg::*;
  import lrq_lsu_pkg::*;
();

  localparam int LOAD_PORTS   = 2;
  localparam int ENTRY_NUM    = 4;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_LIMIT  = 200;

  // One line of the vector file
  typedef struct packed {
    miss_req_t  [LOAD_PORTS-1:0] req;
    logic                        mem_en;
    logic                        check;
    miss_resp_t [LOAD_PORTS-1:0] exp;
  } vector_t;

  // Read waiting in the memory model
  typedef struct packed {
    logic [31:0]        due;
    logic [PADDR_W-1:0] addr;
  } mem_read_t;

  logic       clk;
  logic       reset_n;
  miss_req_t  miss      [LOAD_PORTS];
  miss_resp_t miss_resp [LOAD_PORTS];
  logic       ar_valid;
  axi_ar_t    ar;
  logic       ar_ready;
  logic       r_valid;
  axi_r_t     r;
  logic       r_ready;
  refill_t    refill;
  resolve_t   resolve;

  vector_t            vectors     [$];
  mem_read_t          mem_q       [$];
  int                 issue_q     [$];
  logic               model_valid [ENTRY_NUM];
  logic               model_sent  [ENTRY_NUM];
  logic [LINE_W-1:0]  model_line  [ENTRY_NUM];
  logic               new_alloc   [ENTRY_NUM];
  logic [LINE_W-1:0]  new_line    [ENTRY_NUM];
  miss_resp_t         pred_resp   [LOAD_PORTS];
  refill_t            exp_refill;
  resolve_t           exp_resolve;
  logic               ar_stalled;
  logic [PADDR_W-1:0] stalled_addr;
  int                 cycle;
  int                 timeout_limit;
  int                 seed;

  lrq_top #(
    .LOAD_PORTS (LOAD_PORTS),
    .ENTRY_NUM  (ENTRY_NUM)
  ) u_lrq_top (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_miss      (miss),
    .o_miss_resp (miss_resp),
    .o_ar_valid  (ar_valid),
    .o_ar        (ar),
    .i_ar_ready  (ar_ready),
    .i_r_valid   (r_valid),
    .i_r         (r),
    .o_r_ready   (r_ready),
    .o_refill    (refill),
    .o_resolve   (resolve)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (timeout_limit > 0 && cycle > timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // Checks
  // --------------------

  task automatic check_equal(input string name, input logic [95:0] exp,
                             input logic [95:0] act);
    assert (act === exp) else begin
      $display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("Error at time %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "check failed");
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------

  task automatic load_vectors();
    int          fd;
    int          count;
    string       text;
    logic [31:0] f [12];
    vector_t     vec;

    fd = $fopen("lrq_vectors.txt", "r");
    check_true(fd != 0, "cannot open lrq_vectors.txt");
    while ($fgets(text, fd) != 0) begin
      if (text.len() < 2 || text.substr(0, 0) == "#") begin
        continue;
      end
      count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                      f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
      check_true(count == 12, "malformed line in lrq_vectors.txt");
      vec = '0;
      for (int p = 0; p < LOAD_PORTS; p++) begin
        vec.req[p].valid        = f[2*p][0];
        vec.req[p].paddr        = f[2*p+1];
        vec.exp[p].full         = f[6+3*p][0];
        vec.exp[p].conflict     = f[7+3*p][0];
        vec.exp[p].index_oh     = f[8+3*p][ENTRY_MAX-1:0];
      end
      vec.mem_en = f[4][0];
      vec.check  = f[5][0];
      vectors.push_back(vec);
    end
    $fclose(fd);
    check_true(vectors.size() > 0, "lrq_vectors.txt holds no vectors");
  endtask

  // Memory answers in AR order once the delay has passed
  task automatic drive_inputs(input vector_t vec);
    for (int p = 0; p < LOAD_PORTS; p++) begin
      miss[p] = vec.req[p];
    end
    ar_ready = vec.mem_en && ($random(seed) % 2 != 0);
    if (mem_q.size() > 0 && mem_q[0].due <= cycle) begin
      r_valid = 1'b1;
      r.rdata = {mem_q[0].addr, ~mem_q[0].addr};
      r.rresp = 2'b00;
    end else begin
      r_valid = 1'b0;
      r       = '0;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Conflict is resolved before the lowest free entry in port order
  task automatic predict_requests();
    logic              taken     [ENTRY_NUM];
    int                port_slot [LOAD_PORTS];
    logic [LINE_W-1:0] line;
    int                slot;

    for (int b = 0; b < ENTRY_NUM; b++) begin
      taken[b]     = model_valid[b];
      new_alloc[b] = 1'b0;
      new_line[b]  = '0;
    end
    for (int p = 0; p < LOAD_PORTS; p++) begin
      pred_resp[p] = '0;
      port_slot[p] = -1;
      if (!miss[p].valid) begin
        continue;
      end
      line = miss[p].paddr[PADDR_W-1:LINE_OFF_W];
      slot = -1;
      for (int b = 0; b < ENTRY_NUM; b++) begin
        if (model_valid[b] && model_line[b] == line) begin
          slot = b;
        end
      end
      for (int q = 0; q < p; q++) begin
        if (port_slot[q] >= 0 && miss[q].paddr[PADDR_W-1:LINE_OFF_W] == line) begin
          slot = port_slot[q];
        end
      end
      if (slot >= 0) begin
        pred_resp[p].conflict       = 1'b1;
        pred_resp[p].index_oh[slot] = 1'b1;
      end else begin
        for (int b = ENTRY_NUM - 1; b >= 0; b--) begin
          if (!taken[b]) begin
            slot = b;
          end
        end
        if (slot < 0) begin
          pred_resp[p].full = 1'b1;
        end else begin
          taken[slot]                 = 1'b1;
          port_slot[p]                = slot;
          new_alloc[slot]             = 1'b1;
          new_line[slot]              = line;
          pred_resp[p].index_oh[slot] = 1'b1;
        end
      end
    end
  endtask

  task automatic check_cycle(input vector_t vec);
    miss_resp_t        exp;
    mem_read_t         rd;
    logic [LINE_W-1:0] line;
    logic [PADDR_W-1:0] base;
    int                slot;

    // Registered outputs from the previous edge
    check_equal("o_refill.valid", exp_refill.valid, refill.valid);
    check_equal("o_resolve.valid", exp_resolve.valid, resolve.valid);
    if (exp_refill.valid) begin
      check_equal("o_refill.line", exp_refill.line, refill.line);
      check_equal("o_refill.data", exp_refill.data, refill.data);
      check_equal("o_resolve.index_oh", exp_resolve.index_oh, resolve.index_oh);
    end

    predict_requests();
    for (int p = 0; p < LOAD_PORTS; p++) begin
      exp = vec.check ? vec.exp[p] : pred_resp[p];
      check_equal($sformatf("o_miss_resp[%0d].full", p), exp.full, miss_resp[p].full);
      check_equal($sformatf("o_miss_resp[%0d].conflict", p), exp.conflict,
                  miss_resp[p].conflict);
      check_equal($sformatf("o_miss_resp[%0d].index_oh", p), exp.index_oh,
                  miss_resp[p].index_oh);
    end

    if (ar_stalled) begin
      check_true(ar_valid, "o_ar_valid dropped before the AR handshake");
      check_equal("o_ar.araddr", stalled_addr, ar.araddr);
    end
    if (ar_valid) begin
      check_equal("o_ar.araddr offset", 0, ar.araddr[LINE_OFF_W-1:0]);
      check_equal("o_ar.arprot", 0, ar.arprot);
    end

    // The R side of the coming rising edge goes first
    exp_refill  = '0;
    exp_resolve = '0;
    if (r_valid && r_ready) begin
      slot = issue_q.pop_front();
      mem_q.delete(0);
      base                        = {model_line[slot], {LINE_OFF_W{1'b0}}};
      exp_refill.valid            = 1'b1;
      exp_refill.line             = model_line[slot];
      exp_refill.data             = {base, ~base};
      exp_resolve.valid           = 1'b1;
      exp_resolve.index_oh[slot]  = 1'b1;
      model_valid[slot]           = 1'b0;
      model_sent[slot]            = 1'b0;
    end
    if (ar_valid && ar_ready) begin
      line = ar.araddr[PADDR_W-1:LINE_OFF_W];
      slot = -1;
      for (int b = 0; b < ENTRY_NUM; b++) begin
        if (model_valid[b] && !model_sent[b] && model_line[b] == line) begin
          slot = b;
        end
      end
      check_true(slot >= 0, "AR address matches no entry waiting to be issued");
      model_sent[slot] = 1'b1;
      issue_q.push_back(slot);
      rd.due  = cycle + 1 + ($unsigned($random(seed)) % 4);
      rd.addr = ar.araddr;
      mem_q.push_back(rd);
    end
    for (int b = 0; b < ENTRY_NUM; b++) begin
      if (new_alloc[b]) begin
        model_valid[b] = 1'b1;
        model_sent[b]  = 1'b0;
        model_line[b]  = new_line[b];
      end
    end
    ar_stalled   = ar_valid && !ar_ready;
    stalled_addr = ar.araddr;
  endtask

  function automatic logic queue_drained();
    logic busy;

    busy = exp_refill.valid || (issue_q.size() > 0);
    for (int b = 0; b < ENTRY_NUM; b++) begin
      busy = busy | model_valid[b];
    end
    return !busy;
  endfunction

  task automatic step_cycle(input vector_t vec);
    @(negedge clk);
    drive_inputs(vec);
    #(CLK_PERIOD / 4);
    check_cycle(vec);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    vector_t idle;

    seed          = 32'h123befe1;
    cycle         = 0;
    timeout_limit = 0;
    reset_n       = 1'b1;
    ar_ready      = 1'b0;
    r_valid       = 1'b0;
    r             = '0;
    for (int p = 0; p < LOAD_PORTS; p++) begin
      miss[p] = '0;
    end
    for (int b = 0; b < ENTRY_NUM; b++) begin
      model_valid[b] = 1'b0;
      model_sent[b]  = 1'b0;
      model_line[b]  = '0;
    end
    exp_refill    = '0;
    exp_resolve   = '0;
    ar_stalled    = 1'b0;
    stalled_addr  = '0;
    idle          = '0;
    idle.mem_en   = 1'b1;

    load_vectors();
    timeout_limit = vectors.size() + DRAIN_LIMIT;

    repeat (RESET_CYCLES) @(posedge clk);
    #(CLK_PERIOD / 4);
    check_equal("o_ar_valid", 0, ar_valid);
    check_equal("o_refill.valid", 0, refill.valid);
    check_equal("o_resolve.valid", 0, resolve.valid);
    check_equal("o_r_ready", 1, r_ready);
    @(negedge clk);
    reset_n = 1'b0;

    foreach (vectors[i]) begin
      step_cycle(vectors[i]);
    end
    // Drain with memory on until every entry is resolved
    while (!queue_drained()) begin
      step_cycle(idle);
    end
    // No entry may be left waiting to issue
    check_equal("o_ar_valid", 0, ar_valid);

    $display("Verification passed");
    $finish;
  end

endmodule

// File: lrq_top.sv
`timescale 1ns/100ps

module lrq_top
  import lrq_mem_pkg::*;
  import lrq_lsu_pkg::*;
#(
  parameter int LOAD_PORTS = 2,
  parameter int ENTRY_NUM  = 4
) (
  input  logic       i_clk,
  input  logic       i_reset_n,

  input  miss_req_t  i_miss      [LOAD_PORTS],
  output miss_resp_t o_miss_resp [LOAD_PORTS],

  output logic       o_ar_valid,
  output axi_ar_t    o_ar,
  input  logic       i_ar_ready,

  input  logic       i_r_valid,
  input  axi_r_t     i_r,
  output logic       o_r_ready,

  output refill_t    o_refill,
  output resolve_t   o_resolve
);

  lrq_entry_t                   w_entries    [ENTRY_NUM];
  logic [ENTRY_MAX-1:0]         w_alloc_valid;
  logic [LINE_W-1:0]            w_alloc_line [ENTRY_NUM];
  logic [ENTRY_MAX-1:0]         w_clear_oh;
  logic                         w_issue_fire;
  logic [$clog2(ENTRY_NUM)-1:0] w_issue_idx;

  lrq_req_decode #(
    .LOAD_PORTS (LOAD_PORTS),
    .ENTRY_NUM  (ENTRY_NUM)
  ) u_req_decode (
    .i_miss        (i_miss),
    .i_entries     (w_entries),
    .o_miss_resp   (o_miss_resp),
    .o_alloc_valid (w_alloc_valid),
    .o_alloc_line  (w_alloc_line)
  );

  lrq_entry_array #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_entry_array (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc_valid (w_alloc_valid),
    .i_alloc_line  (w_alloc_line),
    .i_clear_oh    (w_clear_oh),
    .o_entries     (w_entries),
    .o_ar_valid    (o_ar_valid),
    .o_ar          (o_ar),
    .i_ar_ready    (i_ar_ready),
    .o_issue_fire  (w_issue_fire),
    .o_issue_idx   (w_issue_idx)
  );

  lrq_refill_result #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_refill_result (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue_fire (w_issue_fire),
    .i_issue_idx  (w_issue_idx),
    .i_r_valid    (i_r_valid),
    .i_r          (i_r),
    .o_r_ready    (o_r_ready),
    .i_entries    (w_entries),
    .o_clear_oh   (w_clear_oh),
    .o_refill     (o_refill),
    .o_resolve    (o_resolve)
  );

endmodule

// File: lrq_refill_result.sv
`timescale 1ns/100ps

module lrq_refill_result
  import lrq_mem_pkg::*;
  import lrq_lsu_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_issue_fire,
  input  logic [$clog2(ENTRY_NUM)-1:0] i_issue_idx,

  input  logic                         i_r_valid,
  input  axi_r_t                       i_r,
  output logic                         o_r_ready,

  input  lrq_entry_t                   i_entries [ENTRY_NUM],
  output logic [ENTRY_MAX-1:0]         o_clear_oh,
  output refill_t                      o_refill,
  output resolve_t                     o_resolve
);

  localparam int IDX_W = $clog2(ENTRY_NUM);

  logic [IDX_W-1:0] r_fifo [ENTRY_NUM];
  logic [IDX_W-1:0] r_wr_ptr;
  logic [IDX_W-1:0] r_rd_ptr;
  logic [IDX_W-1:0] w_head_idx;
  logic             w_r_fire;

  function automatic logic [IDX_W-1:0] ptr_next(input logic [IDX_W-1:0] ptr);
    ptr_next = (ptr == IDX_W'(ENTRY_NUM - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------
  // Outstanding index FIFO
  // --------------------

  // Every R beat answers an AR already pushed here
  assign o_r_ready  = 1'b1;
  assign w_r_fire   = i_r_valid & o_r_ready;
  assign w_head_idx = r_fifo[r_rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_issue_fire) begin
      r_fifo[r_wr_ptr] <= i_issue_idx;
    end
  end

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (i_issue_fire) begin
        r_wr_ptr <= ptr_next(r_wr_ptr);
      end
      if (w_r_fire) begin
        r_rd_ptr <= ptr_next(r_rd_ptr);
      end
    end
  end

  // --------------------
  // Refill and resolve
  // --------------------

  assign o_clear_oh = w_r_fire ? (ENTRY_MAX'(1) << w_head_idx) : '0;

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      o_refill.valid  <= 1'b0;
      o_resolve.valid <= 1'b0;
    end else begin
      o_refill.valid  <= w_r_fire;
      o_resolve.valid <= w_r_fire;
      if (w_r_fire) begin
        o_refill.line      <= i_entries[w_head_idx].line;
        o_refill.data      <= i_r.rdata;
        o_resolve.index_oh <= ENTRY_MAX'(1) << w_head_idx;
      end
    end
  end

endmodule

// File: lrq_entry_array.sv
`timescale 1ns/100ps

module lrq_entry_array
  import lrq_mem_pkg::*;
  import lrq_lsu_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic [ENTRY_MAX-1:0]         i_alloc_valid,
  input  logic [LINE_W-1:0]            i_alloc_line [ENTRY_NUM],
  input  logic [ENTRY_MAX-1:0]         i_clear_oh,
  output lrq_entry_t                   o_entries    [ENTRY_NUM],

  output logic                         o_ar_valid,
  output axi_ar_t                      o_ar,
  input  logic                         i_ar_ready,

  output logic                         o_issue_fire,
  output logic [$clog2(ENTRY_NUM)-1:0] o_issue_idx
);

  localparam int IDX_W = $clog2(ENTRY_NUM);

  lrq_entry_t           r_entries [ENTRY_NUM];
  logic [ENTRY_NUM-1:0] w_ready;
  logic [ENTRY_NUM-1:0] w_ready_oh;
  logic [IDX_W-1:0]     w_low_idx;
  logic [IDX_W-1:0]     w_sel_idx;
  lrq_entry_t           w_sel_entry;
  logic                 r_hold;
  logic [IDX_W-1:0]     r_hold_idx;

  // --------------------
  // Issue selection
  // --------------------

  for (genvar b = 0; b < ENTRY_NUM; b++) begin : g_ready
    assign w_ready[b] = r_entries[b].valid & !r_entries[b].sent;
  end

  assign w_ready_oh = w_ready & (~w_ready + 1'b1);

  always_comb begin
    w_low_idx = '0;
    for (int b = 0; b < ENTRY_NUM; b++) begin
      if (w_ready_oh[b]) begin
        w_low_idx = IDX_W'(b);
      end
    end
  end

  // A stalled AR keeps its entry even if a lower one is allocated
  assign w_sel_idx   = r_hold ? r_hold_idx : w_low_idx;
  assign w_sel_entry = r_entries[w_sel_idx];

  assign o_ar_valid  = r_hold | (|w_ready);
  assign o_ar.araddr = {w_sel_entry.line, {LINE_OFF_W{1'b0}}};
  assign o_ar.arprot = 3'b000;

  assign o_issue_fire = o_ar_valid & i_ar_ready;
  assign o_issue_idx  = w_sel_idx;

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_hold <= 1'b0;
    end else begin
      r_hold <= o_ar_valid & !i_ar_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ar_valid && !i_ar_ready) begin
      r_hold_idx <= w_sel_idx;
    end
  end

  // --------------------
  // Entry storage
  // --------------------

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      for (int b = 0; b < ENTRY_NUM; b++) begin
        r_entries[b].valid <= 1'b0;
        r_entries[b].sent  <= 1'b0;
      end
    end else begin
      for (int b = 0; b < ENTRY_NUM; b++) begin
        if (i_alloc_valid[b]) begin
          r_entries[b].valid <= 1'b1;
          r_entries[b].sent  <= 1'b0;
          r_entries[b].line  <= i_alloc_line[b];
        end else if (i_clear_oh[b]) begin
          r_entries[b].valid <= 1'b0;
          r_entries[b].sent  <= 1'b0;
        end else if (o_issue_fire && w_sel_idx == IDX_W'(b)) begin
          r_entries[b].sent <= 1'b1;
        end
      end
    end
  end

  assign o_entries = r_entries;

endmodule

// File: lrq_req_decode.sv
`timescale 1ns/100ps

module lrq_req_decode
  import lrq_mem_pkg::*;
  import lrq_lsu_pkg::*;
#(
  parameter int LOAD_PORTS = 2,
  parameter int ENTRY_NUM  = 4
) (
  input  miss_req_t            i_miss        [LOAD_PORTS],
  input  lrq_entry_t           i_entries     [ENTRY_NUM],
  output miss_resp_t           o_miss_resp   [LOAD_PORTS],
  output logic [ENTRY_MAX-1:0] o_alloc_valid,
  output logic [LINE_W-1:0]    o_alloc_line  [ENTRY_NUM]
);

  logic [LINE_W-1:0] w_req_line [LOAD_PORTS];

  for (genvar p = 0; p < LOAD_PORTS; p++) begin : g_req_line
    assign w_req_line[p] = i_miss[p].paddr[PADDR_W-1:LINE_OFF_W];
  end

  // Ports are handled in order, lower ports win free entries first
  always_comb begin
    logic [ENTRY_MAX-1:0]  free_mask;
    logic [ENTRY_MAX-1:0]  pick_oh;
    logic [LOAD_PORTS-1:0] port_alloc;
    logic [ENTRY_MAX-1:0]  port_oh [LOAD_PORTS];

    free_mask     = '0;
    pick_oh       = '0;
    port_alloc    = '0;
    o_alloc_valid = '0;
    for (int b = 0; b < ENTRY_NUM; b++) begin
      free_mask[b]    = !i_entries[b].valid;
      o_alloc_line[b] = '0;
    end

    for (int p = 0; p < LOAD_PORTS; p++) begin
      o_miss_resp[p] = '0;
      port_oh[p]     = '0;
      if (i_miss[p].valid) begin
        // Line already held by an entry
        for (int b = 0; b < ENTRY_NUM; b++) begin
          if (i_entries[b].valid && i_entries[b].line == w_req_line[p]) begin
            o_miss_resp[p].conflict    = 1'b1;
            o_miss_resp[p].index_oh[b] = 1'b1;
          end
        end

        // Same line taken by a lower port this cycle
        for (int q = 0; q < p; q++) begin
          if (port_alloc[q] && w_req_line[q] == w_req_line[p]) begin
            o_miss_resp[p].conflict = 1'b1;
            o_miss_resp[p].index_oh = port_oh[q];
          end
        end

        if (!o_miss_resp[p].conflict) begin
          // Lowest remaining free entry
          pick_oh = free_mask & (~free_mask + 1'b1);
          if (pick_oh == '0) begin
            o_miss_resp[p].full = 1'b1;
          end else begin
            port_alloc[p]           = 1'b1;
            port_oh[p]              = pick_oh;
            free_mask               = free_mask & ~pick_oh;
            o_alloc_valid           = o_alloc_valid | pick_oh;
            o_miss_resp[p].index_oh = pick_oh;
            for (int b = 0; b < ENTRY_NUM; b++) begin
              if (pick_oh[b]) begin
                o_alloc_line[b] = w_req_line[p];
              end
            end
          end
        end
      end
    end
  end

endmodule

// File: lrq_lsu_pkg.sv
package lrq_lsu_pkg;

  import lrq_mem_pkg::*;

  // Upper bound on entries, sets the one-hot vector widths
  localparam int ENTRY_MAX = 16;

  // --------------------
  // Load port side
  // --------------------

  // Miss reported by one load pipeline
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } miss_req_t;

  // Same-cycle reply to a load pipeline
  typedef struct packed {
    logic                 full;
    logic                 conflict;
    logic [ENTRY_MAX-1:0] index_oh;
  } miss_resp_t;

  // --------------------
  // Queue state
  // --------------------

  typedef struct packed {
    logic              valid;
    logic              sent;
    logic [LINE_W-1:0] line;
  } lrq_entry_t;

  // --------------------
  // Refill side
  // --------------------

  // Line data back to the cache
  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] line;
    logic [DATA_W-1:0] data;
  } refill_t;

  // Wakes loads waiting on the entry
  typedef struct packed {
    logic                 valid;
    logic [ENTRY_MAX-1:0] index_oh;
  } resolve_t;

endpackage

// File: lrq_mem_pkg.sv
package lrq_mem_pkg;

  // --------------------
  // Line geometry
  // --------------------

  // Physical address width
  localparam int PADDR_W = 32;

  // One line is 8 bytes
  localparam int LINE_OFF_W = 3;

  // A single R beat carries the whole line
  localparam int DATA_W = 64;

  // Line address, offset dropped
  localparam int LINE_W = PADDR_W - LINE_OFF_W;

  // --------------------
  // AXI4-Lite read channels
  // --------------------

  // AR payload
  typedef struct packed {
    logic [PADDR_W-1:0] araddr;
    logic [2:0]         arprot;
  } axi_ar_t;

  // R payload
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axi_r_t;

endpackage
